//--- source/ppu_pkg.sv
//--------------------------------------------------------------------------
// shared constants and types for the background-only picture unit
// one clock per dot: 456 clocks per line, 154 lines per frame
// register addresses are the low byte of the 0xFFxx i/o window
//--------------------------------------------------------------------------
package ppu_pkg;

	//--------------------------------------------------------------------------
	// cpu register addresses
	localparam logic [7:0] addr_lcdc = 8'h40;
	localparam logic [7:0] addr_stat = 8'h41;
	localparam logic [7:0] addr_scy  = 8'h42;
	localparam logic [7:0] addr_scx  = 8'h43;
	localparam logic [7:0] addr_ly   = 8'h44;
	localparam logic [7:0] addr_lyc  = 8'h45;
	localparam logic [7:0] addr_bgp  = 8'h47;

	// palette after reset, shades 3,3,3,0
	localparam logic [7:0] bgp_reset = 8'hfc;

	//--------------------------------------------------------------------------
	// line and frame timing
	localparam logic [8:0] line_clocks   = 9'd456;
	localparam logic [7:0] frame_lines   = 8'd154;
	// lines 144..153 are vblank
	localparam logic [7:0] visible_lines = 8'd144;
	// oam search covers h 0..79
	localparam logic [8:0] oam_clocks    = 9'd80;
	localparam logic [7:0] screen_width  = 8'd160;

	// stat mode code, as read in STAT bits 1..0
	typedef enum logic [1:0] {
		mode_hblank = 2'd0,
		mode_vblank = 2'd1,
		mode_oam    = 2'd2,
		mode_xfer   = 2'd3
	} ppu_mode_e;

	// two clocks per phase, selected by h[2:1]
	typedef enum logic [1:0] {
		phase_map     = 2'd0,
		phase_data_lo = 2'd1,
		phase_data_hi = 2'd2,
		phase_load    = 2'd3
	} fetch_phase_e;

	// configuration seen by the datapath
	typedef struct packed {
		logic       lcd_on;
		logic       tile_data_sel;
		logic       bg_map_sel;
		logic       bg_on;
		logic       int_lyc;
		logic       int_oam;
		logic       int_vblank;
		logic       int_hblank;
		logic [7:0] bgp;
	} ppu_cfg_t;

	// per-clock timing from the control block
	typedef struct packed {
		logic [7:0]   line;
		logic         xfer;
		fetch_phase_e phase;
		logic         sample;
		logic         line_start;
		logic [7:0]   scx_r;
		logic [7:0]   scy_r;
	} ppu_timing_t;

endpackage

//--- source/ppu_regs.sv
//--------------------------------------------------------------------------
// cpu visible registers 0x40..0x47
// writes to LY are dropped, unmapped addresses read 0xFF
// the read path is combinational on cpu_addr
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module ppu_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_sel_reg,
	input  logic               cpu_wr,
	input  logic [7:0]         cpu_addr,
	input  logic [7:0]         cpu_di,
	output logic [7:0]         cpu_do,
	input  ppu_pkg::ppu_mode_e mode,
	input  logic               lyc_match,
	input  logic [7:0]         line,
	output ppu_pkg::ppu_cfg_t  cfg,
	output logic [7:0]         scx,
	output logic [7:0]         scy,
	output logic [7:0]         lyc
);
	import ppu_pkg::*;

	logic [7:0] lcdc;
	// STAT bits 6..3: lyc, oam, vblank, hblank enables
	logic [3:0] stat_en;
	logic [7:0] bgp;

	//--------------------------------------------------------------------------
	// write decode
	always_ff @(posedge clk) begin
		if (reset) begin
			// screen starts off so the cpu can fill vram
			lcdc    <= 8'h00;
			stat_en <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			bgp     <= bgp_reset;
		end else if (cpu_sel_reg && cpu_wr) begin
			case (cpu_addr)
				addr_lcdc: lcdc    <= cpu_di;
				addr_stat: stat_en <= cpu_di[6:3];
				addr_scy:  scy     <= cpu_di;
				addr_scx:  scx     <= cpu_di;
				addr_lyc:  lyc     <= cpu_di;
				addr_bgp:  bgp     <= cpu_di;
				// LY is read only
				default: ;
			endcase
		end
	end

	// only the background bits of LCDC matter here
	always_comb begin
		cfg.lcd_on        = lcdc[7];
		cfg.tile_data_sel = lcdc[4];
		cfg.bg_map_sel    = lcdc[3];
		cfg.bg_on         = lcdc[0];
		cfg.int_lyc       = stat_en[3];
		cfg.int_oam       = stat_en[2];
		cfg.int_vblank    = stat_en[1];
		cfg.int_hblank    = stat_en[0];
		cfg.bgp           = bgp;
	end

	//--------------------------------------------------------------------------
	// read mux
	always_comb begin
		case (cpu_addr)
			addr_lcdc: cpu_do = lcdc;
			// bit 7 always reads one
			addr_stat: cpu_do = {1'b1, stat_en, lyc_match, mode};
			addr_scy:  cpu_do = scy;
			addr_scx:  cpu_do = scx;
			addr_ly:   cpu_do = line;
			addr_lyc:  cpu_do = lyc;
			addr_bgp:  cpu_do = bgp;
			default:   cpu_do = 8'hff;
		endcase
	end

endmodule

//--- source/ppu_ctrl.sv
//--------------------------------------------------------------------------
// line/frame counters, mode decode and stat interrupt
// scx and scy are sampled once per line at h = 78
// with lcd off the counters sit at zero and no interrupt is raised
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module ppu_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  logic [7:0]           scx,
	input  logic [7:0]           scy,
	input  logic [7:0]           lyc,
	output ppu_pkg::ppu_timing_t tim,
	output ppu_pkg::ppu_mode_e   mode,
	output logic                 lyc_match,
	output logic                 irq
);
	import ppu_pkg::*;

	// dot counter 0..455 and line counter 0..153
	logic [8:0] h;
	logic [7:0] v;
	logic [7:0] scx_r;
	logic [7:0] scy_r;
	logic       extra;
	logic [8:0] xfer_end;
	logic       stat_cond;

	//--------------------------------------------------------------------------
	// counters
	always_ff @(posedge clk) begin
		if (reset || !cfg.lcd_on) begin
			h <= '0;
			v <= '0;
		end else if (h == line_clocks - 9'd1) begin
			h <= '0;
			// wrap after the last vblank line
			if (v == frame_lines - 8'd1)
				v <= '0;
			else
				v <= v + 8'd1;
		end else begin
			h <= h + 9'd1;
		end
	end

	// scrolls are taken two clocks before xfer and stay still for the line
	always_ff @(posedge clk) begin
		if (reset) begin
			scx_r <= '0;
			scy_r <= '0;
		end else if (h == oam_clocks - 9'd2) begin
			scx_r <= scx;
			scy_r <= scy;
		end
	end

	// a fine x scroll needs one more tile, so xfer grows by 8 clocks
	assign extra    = (scx_r[2:0] != 3'd0);
	assign xfer_end = oam_clocks + 9'(screen_width) + (extra ? 9'd8 : 9'd0);

	always_comb begin
		if (!cfg.lcd_on)
			mode = mode_hblank;
		else if (v >= visible_lines)
			mode = mode_vblank;
		else if (h < oam_clocks)
			mode = mode_oam;
		else if (h < xfer_end)
			mode = mode_xfer;
		else
			mode = mode_hblank;
	end

	assign lyc_match = (v == lyc);

	// fetch slot timing for the datapath
	always_comb begin
		tim.line       = v;
		tim.xfer       = (mode == mode_xfer);
		tim.phase      = fetch_phase_e'(h[2:1]);
		// vram data is taken on the odd clock of each slot
		tim.sample     = h[0];
		tim.line_start = (h == oam_clocks - 9'd1);
		tim.scx_r      = scx_r;
		tim.scy_r      = scy_r;
	end

	//--------------------------------------------------------------------------
	// any enabled stat source gives one interrupt pulse
	always_comb begin
		stat_cond = 1'b0;
		// oam start on every line including vblank
		if (cfg.int_oam && h == 9'd0)
			stat_cond = 1'b1;
		if (cfg.int_lyc && h == 9'd1 && lyc_match)
			stat_cond = 1'b1;
		// last clock of line 143
		if (cfg.int_vblank && h == line_clocks - 9'd1 && v == visible_lines - 8'd1)
			stat_cond = 1'b1;
		// first hblank clock of a visible line
		if (cfg.int_hblank && h == xfer_end && v < visible_lines)
			stat_cond = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= cfg.lcd_on && stat_cond;
	end

	a_h_range: assert property (@(posedge clk) disable iff (reset)
		h < line_clocks)
		else $error("h past end of line");

endmodule

//--- source/bg_fetch.sv
//--------------------------------------------------------------------------
// background tile fetch
// map, low byte, high byte, then a load slot with no vram access
// vram_data is sampled in the same cycle the address is out
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module bg_fetch (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  ppu_pkg::ppu_timing_t tim,
	output logic                 vram_rd,
	output logic [12:0]          vram_addr,
	input  logic [7:0]           vram_data,
	output logic [7:0]           tile_lo,
	output logic [7:0]           tile_hi,
	output logic                 load
);
	import ppu_pkg::*;

	// background line = LY + scy, row in bits 7..3, pixel row in 2..0
	logic [7:0] bg_line;
	logic [4:0] col;
	logic [7:0] tile_num;
	logic       tile_a12;
	logic       take;

	assign bg_line = tim.line + tim.scy_r;

	// signed tile numbers are based at 0x1000, so bit 12 is ~tile[7]
	assign tile_a12 = cfg.tile_data_sel ? 1'b0 : ~tile_num[7];

	always_comb begin
		case (tim.phase)
			// 0x1800 or 0x1c00, 32 entries per map row
			phase_map:     vram_addr = {2'b11, cfg.bg_map_sel, bg_line[7:3], col};
			phase_data_lo: vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b0};
			default:       vram_addr = {tile_a12, tile_num, bg_line[2:0], 1'b1};
		endcase
	end

	assign vram_rd = tim.xfer && (tim.phase != phase_load);
	assign take    = tim.xfer && tim.sample;
	assign load    = take && (tim.phase == phase_load);

	// byte latches, one per slot
	always_ff @(posedge clk) begin
		if (take) begin
			case (tim.phase)
				phase_map:     tile_num <= vram_data;
				phase_data_lo: tile_lo  <= vram_data;
				phase_data_hi: tile_hi  <= vram_data;
				default: ;
			endcase
		end
	end

	// map column, coarse scroll at line start then one step per tile
	always_ff @(posedge clk) begin
		if (reset)
			col <= '0;
		else if (tim.line_start)
			col <= tim.scx_r[7:3];
		else if (load)
			col <= col + 5'd1;
	end

	a_rd_visible: assert property (@(posedge clk) disable iff (reset)
		vram_rd |-> tim.xfer && cfg.lcd_on && tim.line < visible_lines)
		else $error("vram read outside visible xfer");

endmodule

//--- source/pixel_out.sv
//--------------------------------------------------------------------------
// pixel shifters, fine x discard and palette
// the first scx[2:0] pixels of a line are dropped
// exactly 160 strobes per visible line, latency follows the fetch
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module pixel_out (
	input  logic                 clk,
	input  logic                 reset,
	input  ppu_pkg::ppu_cfg_t    cfg,
	input  ppu_pkg::ppu_timing_t tim,
	input  logic [7:0]           tile_lo,
	input  logic [7:0]           tile_hi,
	input  logic                 load,
	output logic                 lcd_clkena,
	output logic [1:0]           lcd_data
);
	import ppu_pkg::*;

	logic [7:0] sh_lo;
	logic [7:0] sh_hi;
	// shifters hold real tile data since the first load of the line
	logic       valid;
	logic [2:0] discard;
	logic [7:0] pcnt;
	logic [1:0] color;
	logic [1:0] shade;
	logic       emit;

	// leftmost pixel sits in bit 7
	assign color = {sh_hi[7], sh_lo[7]};
	assign emit  = valid && (pcnt != screen_width) && (discard == 3'd0);

	// bgp holds four 2-bit shades, colour 0 in bits 1..0
	assign shade = cfg.bg_on ? cfg.bgp[{color, 1'b0} +: 2] : 2'b00;

	//--------------------------------------------------------------------------
	// one pixel per clock; a load replaces the last pixel of the old tile
	always_ff @(posedge clk) begin
		if (load) begin
			sh_lo <= tile_lo;
			sh_hi <= tile_hi;
		end else begin
			sh_lo <= {sh_lo[6:0], 1'b0};
			sh_hi <= {sh_hi[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !cfg.lcd_on) begin
			valid   <= 1'b0;
			discard <= '0;
			pcnt    <= '0;
		end else if (tim.line_start) begin
			valid   <= 1'b0;
			discard <= tim.scx_r[2:0];
			pcnt    <= '0;
		end else begin
			if (load)
				valid <= 1'b1;
			// drop fine scroll pixels first, then count the visible ones
			if (valid && pcnt != screen_width) begin
				if (discard != 3'd0)
					discard <= discard - 3'd1;
				else
					pcnt <= pcnt + 8'd1;
			end
		end
	end

	// registered to the lcd
	always_ff @(posedge clk) begin
		if (reset)
			lcd_clkena <= 1'b0;
		else
			lcd_clkena <= emit;
	end

	always_ff @(posedge clk) begin
		lcd_data <= shade;
	end

	a_pcnt_limit: assert property (@(posedge clk) disable iff (reset)
		pcnt <= screen_width)
		else $error("pixel count past line width");

endmodule

//--- source/ppu_top.sv
//--------------------------------------------------------------------------
// background-only picture unit, top level
// vram_data must answer in the same cycle as vram_addr
// the lcd has to take every lcd_clkena strobe, there is no stall
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module ppu_top (
	input  logic               clk,
	input  logic               reset,
	// cpu register port
	input  logic               cpu_sel_reg,
	input  logic               cpu_wr,
	input  logic [7:0]         cpu_addr,
	input  logic [7:0]         cpu_di,
	output logic [7:0]         cpu_do,
	// lcd side
	output logic               lcd_on,
	output logic               lcd_clkena,
	output logic [1:0]         lcd_data,
	output logic               irq,
	output ppu_pkg::ppu_mode_e mode,
	// vram read port
	output logic               vram_rd,
	output logic [12:0]        vram_addr,
	input  logic [7:0]         vram_data
);
	import ppu_pkg::*;

	ppu_cfg_t    cfg;
	ppu_timing_t tim;
	logic [7:0]  scx;
	logic [7:0]  scy;
	logic [7:0]  lyc;
	logic        lyc_match;
	logic [7:0]  tile_lo;
	logic [7:0]  tile_hi;
	logic        load;

	assign lcd_on = cfg.lcd_on;

	ppu_regs ppu_regs_i (
		.clk(clk), .reset(reset),
		.cpu_sel_reg(cpu_sel_reg), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
		.cpu_di(cpu_di), .cpu_do(cpu_do),
		.mode(mode), .lyc_match(lyc_match), .line(tim.line),
		.cfg(cfg), .scx(scx), .scy(scy), .lyc(lyc)
	);

	ppu_ctrl ppu_ctrl_i (
		.clk(clk), .reset(reset), .cfg(cfg),
		.scx(scx), .scy(scy), .lyc(lyc),
		.tim(tim), .mode(mode), .lyc_match(lyc_match), .irq(irq)
	);

	bg_fetch bg_fetch_i (
		.clk(clk), .reset(reset), .cfg(cfg), .tim(tim),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.tile_lo(tile_lo), .tile_hi(tile_hi), .load(load)
	);

	pixel_out pixel_out_i (
		.clk(clk), .reset(reset), .cfg(cfg), .tim(tim),
		.tile_lo(tile_lo), .tile_hi(tile_hi), .load(load),
		.lcd_clkena(lcd_clkena), .lcd_data(lcd_data)
	);

	// every readable register comes out of reset defined
	a_cpu_do_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(cpu_do))
		else $error("cpu_do unknown");

	// lcd off forces the counters to zero, so stat must show hblank
	a_off_hblank: assert property (@(posedge clk) disable iff (reset)
		!lcd_on |-> mode == mode_hblank)
		else $error("mode not hblank with lcd off");

endmodule

//--- tests/tb_clock.sv
//--------------------------------------------------------------------------
// free running testbench clock, 4 ns period
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// half period of 2 ns
	always #2 clk = ~clk;

endmodule

//--- tests/tb_check.sv
//--------------------------------------------------------------------------
// watches the picture unit and compares it against a model of the timing
// all DUT outputs are sampled on the rising clock edge
// pixel shades come from a reference that reads the testbench VRAM copy
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_check (
	input  logic       clk,
	input  logic       reset,
	input  logic       lcd_on,
	input  logic       lcd_clkena,
	input  logic [1:0] lcd_data,
	input  logic       irq,
	input  logic [1:0] mode,
	input  logic       vram_rd,
	input  logic       cpu_wr,
	input  logic [7:0] cpu_addr,
	input  logic [7:0] cpu_do,
	input  logic       exp_en,
	input  logic [7:0] exp_do,
	input  logic [7:0] lcdc,
	input  logic [7:0] stat,
	input  logic [7:0] scx,
	input  logic [7:0] scy,
	input  logic [7:0] lyc,
	input  logic [7:0] bgp,
	input  logic       report,
	output int         errors,
	output int         frames_done
);

	// model of the dot and line counters
	int         hm;
	int         vm;
	int         line_strobes;
	int         irq_count;
	int         irq_expected;
	int         xfer_end;
	int         value_errors;
	int         other_errors;
	logic       exp_irq_q;
	logic       lcd_on_q;
	logic       cond;
	logic [1:0] exp_mode;
	logic [1:0] exp_shade;
	logic       exp_rd;

	initial begin
		value_errors = 0;
		other_errors = 0;
		frames_done  = 0;
	end

	assign errors = value_errors + other_errors;

	//--------------------------------------------------------------------------
	// reference shade for screen pixel (x, line)
	function automatic logic [1:0] ref_shade(input int line, input int x,
			input logic [7:0] scx_v, input logic [7:0] scy_v, input logic [7:0] bgp_v,
			input logic [7:0] lcdc_v);
		int         bx;
		int         by;
		int         map_a;
		int         tnum;
		int         row_a;
		int         b;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [1:0] color;
		bx    = (int'(scx_v) + x) % 256;
		by    = (int'(scy_v) + line) % 256;
		// map at 0x1800 or 0x1c00 with 32 tiles per row
		map_a = 'h1800 + (lcdc_v[3] ? 'h400 : 0) + (by / 8) * 32 + bx / 8;
		tnum  = int'(tb_top.vram[map_a]);
		if (lcdc_v[4])
			row_a = tnum * 16;
		else
			row_a = 'h1000 + ((tnum >= 128) ? tnum - 256 : tnum) * 16;
		row_a = row_a + (by % 8) * 2;
		lo    = tb_top.vram[row_a];
		hi    = tb_top.vram[row_a + 1];
		// leftmost pixel is bit 7
		b     = 7 - bx % 8;
		color = {hi[b], lo[b]};
		if (!lcdc_v[0])
			return 2'b00;
		return bgp_v[2 * color +: 2];
	endfunction

	task automatic value_fail(input string name, input logic [7:0] got, input logic [7:0] exp);
		$display("Fail %s: got %h expected %h (line %0d, h %0d)", name, got, exp, vm, hm);
		value_errors++;
	endtask

	//--------------------------------------------------------------------------
	always @(posedge clk) begin
		if (reset) begin
			hm           = 0;
			vm           = 0;
			line_strobes = 0;
			irq_count    = 0;
			exp_irq_q    = 1'b0;
			lcd_on_q     = 1'b0;
		end else begin
			// register reads asked for by the stimulus
			if (exp_en && cpu_do !== exp_do)
				value_fail("cpu_do", cpu_do, exp_do);
			else if (!exp_en && !cpu_wr && cpu_addr == 8'h44 && cpu_do !== 8'(vm))
				value_fail("LY", cpu_do, 8'(vm));
			if (irq !== exp_irq_q)
				value_fail("irq", 8'(irq), 8'(exp_irq_q));
			// lcd_on follows LCDC bit 7 one clock after the write
			if (lcd_on !== lcd_on_q)
				value_fail("lcd_on", 8'(lcd_on), 8'(lcd_on_q));
			lcd_on_q = lcdc[7];
			if (!lcd_on) begin
				if (mode !== 2'd0)
					value_fail("mode", 8'(mode), 8'h00);
				if (lcd_clkena !== 1'b0) begin
					$display("pixel strobe while the LCD is off");
					other_errors++;
				end
				if (vram_rd !== 1'b0) begin
					$display("VRAM read while the LCD is off");
					other_errors++;
				end
				hm           = 0;
				vm           = 0;
				line_strobes = 0;
				irq_count    = 0;
				exp_irq_q    = 1'b0;
			end else begin
				// mode sequence from the line rules
				xfer_end = 240 + ((scx[2:0] != 3'd0) ? 8 : 0);
				if (vm >= 144)
					exp_mode = 2'd1;
				else if (hm < 80)
					exp_mode = 2'd2;
				else if (hm < xfer_end)
					exp_mode = 2'd3;
				else
					exp_mode = 2'd0;
				if (mode !== exp_mode)
					value_fail("mode", 8'(mode), 8'(exp_mode));
				// reads in map, data_lo and data_hi slots only
				exp_rd = (exp_mode == 2'd3) && (((hm >> 1) & 3) != 3);
				if (vram_rd !== exp_rd)
					value_fail("vram_rd", 8'(vram_rd), 8'(exp_rd));
				if (irq)
					irq_count++;
				if (lcd_clkena) begin
					if (vm >= 144) begin
						$display("pixel strobe during vblank on line %0d", vm);
						other_errors++;
					end else if (line_strobes >= 160) begin
						$display("more than 160 strobes on line %0d", vm);
						other_errors++;
					end else begin
						exp_shade = ref_shade(vm, line_strobes, scx, scy, bgp, lcdc);
						if (lcd_data !== exp_shade)
							value_fail("lcd_data", 8'(lcd_data), 8'(exp_shade));
					end
					line_strobes++;
				end
				// stat sources show on irq one clock later
				cond = (stat[5] && hm == 0) ||
					(stat[6] && hm == 1 && vm == int'(lyc)) ||
					(stat[4] && hm == 455 && vm == 143) ||
					(stat[3] && hm == xfer_end && vm < 144);
				exp_irq_q = cond;
				if (hm == 455) begin
					if (vm < 144 && line_strobes != 160) begin
						$display("line %0d gave %0d strobes instead of 160", vm, line_strobes);
						other_errors++;
					end
					line_strobes = 0;
					if (vm == 153) begin
						irq_expected = (stat[5] ? 154 : 0) + (stat[3] ? 144 : 0) +
							(stat[4] ? 1 : 0) + ((stat[6] && lyc < 154) ? 1 : 0);
						if (irq_count != irq_expected) begin
							$display("frame gave %0d irq pulses instead of %0d",
								irq_count, irq_expected);
							other_errors++;
						end
						irq_count = 0;
						frames_done++;
					end
					hm = 0;
					vm = (vm == 153) ? 0 : vm + 1;
				end else begin
					hm++;
				end
			end
		end
	end

	always @(posedge report) begin
		$display("checks done: %0d value errors, %0d other errors, %0d frames",
			value_errors, other_errors, frames_done);
	end

endmodule

//--- tests/tb_top.sv
//--------------------------------------------------------------------------
// testbench top with clock, DUT, VRAM model and CPU stimulus
// configuration is written only while the LCD is off
// VRAM answers in the same cycle and is filled from an xorshift sequence
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_top;
	import ppu_pkg::*;

	localparam int frame_cycles   = int'(line_clocks) * int'(frame_lines);
	localparam int idle_cycles    = 1000;
	// four checked frames plus the idle stretch and some margin
	localparam int timeout_cycles = 4 * frame_cycles + idle_cycles + 2000;

	logic        clk;
	logic        reset;
	logic        cpu_sel_reg;
	logic        cpu_wr;
	logic [7:0]  cpu_addr;
	logic [7:0]  cpu_di;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	ppu_mode_e   mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data;
	logic [7:0]  vram [0:8191];

	// shadow copies of what was written
	logic [7:0]  lcdc_s;
	logic [7:0]  stat_s;
	logic [7:0]  scx_s;
	logic [7:0]  scy_s;
	logic [7:0]  lyc_s;
	logic [7:0]  bgp_s;
	logic        exp_en;
	logic [7:0]  exp_do;
	logic        report;
	logic [31:0] rnd;
	int          errors;
	int          frames_done;
	int          cycles = 0;
	int          a;

	tb_clock tb_clock_i (.clk(clk));

	ppu_top ppu_top_i (
		.clk(clk), .reset(reset),
		.cpu_sel_reg(cpu_sel_reg), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
		.cpu_di(cpu_di), .cpu_do(cpu_do),
		.lcd_on(lcd_on), .lcd_clkena(lcd_clkena), .lcd_data(lcd_data),
		.irq(irq), .mode(mode),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data)
	);

	tb_check tb_check_i (
		.clk(clk), .reset(reset), .lcd_on(lcd_on), .lcd_clkena(lcd_clkena),
		.lcd_data(lcd_data), .irq(irq), .mode(mode), .vram_rd(vram_rd),
		.cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_do(cpu_do),
		.exp_en(exp_en), .exp_do(exp_do),
		.lcdc(lcdc_s), .stat(stat_s), .scx(scx_s), .scy(scy_s), .lyc(lyc_s), .bgp(bgp_s),
		.report(report), .errors(errors), .frames_done(frames_done)
	);

	assign vram_data = vram[vram_addr];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//--------------------------------------------------------------------------
	// cpu accesses are driven on the falling edge
	// the bus idles on the LY address
	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = addr;
		cpu_di      = data;
		case (addr)
			addr_lcdc: lcdc_s = data;
			addr_stat: stat_s = data;
			addr_scy:  scy_s  = data;
			addr_scx:  scx_s  = data;
			addr_lyc:  lyc_s  = data;
			addr_bgp:  bgp_s  = data;
			default: ;
		endcase
		@(negedge clk);
		cpu_wr   = 1'b0;
		cpu_addr = addr_ly;
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [7:0] value);
		@(negedge clk);
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b0;
		cpu_addr    = addr;
		exp_do      = value;
		exp_en      = 1'b1;
		@(negedge clk);
		exp_en   = 1'b0;
		cpu_addr = addr_ly;
	endtask

	// one frame with fresh random scrolls and palette
	task automatic run_frame(input logic [7:0] lcdc, input logic [7:0] stat);
		int start;
		rnd = xorshift(rnd);
		write_reg(addr_scx, rnd[7:0]);
		write_reg(addr_scy, rnd[15:8]);
		write_reg(addr_bgp, rnd[23:16]);
		write_reg(addr_lyc, 8'(rnd[31:24] % 8'd154));
		write_reg(addr_stat, stat);
		start = frames_done;
		write_reg(addr_lcdc, lcdc);
		wait (frames_done != start);
		write_reg(addr_lcdc, lcdc & 8'h7f);
		write_reg(addr_stat, 8'h00);
	endtask

	//--------------------------------------------------------------------------
	initial begin
		reset       = 1'b1;
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
		cpu_addr    = addr_ly;
		cpu_di      = 8'h00;
		exp_en      = 1'b0;
		exp_do      = 8'h00;
		report      = 1'b0;
		lcdc_s      = 8'h00;
		stat_s      = 8'h00;
		scx_s       = 8'h00;
		scy_s       = 8'h00;
		lyc_s       = 8'h00;
		bgp_s       = bgp_reset;
		rnd         = 32'hc8c0_d1b3;
		for (a = 0; a < 8192; a++) begin
			rnd     = xorshift(rnd);
			vram[a] = rnd[7:0];
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// reset values, read back, LY write ignored, STAT layout
		read_expect(addr_lcdc, 8'h00);
		read_expect(addr_bgp, bgp_reset);
		read_expect(8'h46, 8'hff);
		read_expect(8'h4a, 8'hff);
		write_reg(addr_scy, 8'h5a);
		write_reg(addr_scx, 8'h3c);
		write_reg(addr_lyc, 8'h05);
		write_reg(addr_bgp, 8'he4);
		write_reg(addr_ly, 8'h77);
		read_expect(addr_scy, 8'h5a);
		read_expect(addr_scx, 8'h3c);
		read_expect(addr_lyc, 8'h05);
		read_expect(addr_bgp, 8'he4);
		read_expect(addr_ly, 8'h00);
		// top bit set, all enables, LY 0 against LYC 5, hblank
		write_reg(addr_stat, 8'hff);
		read_expect(addr_stat, 8'hf8);
		// coincidence bit comes up with LYC 0
		write_reg(addr_lyc, 8'h00);
		read_expect(addr_stat, 8'hfc);
		write_reg(addr_stat, 8'h00);
		read_expect(addr_stat, 8'h84);

		// LCD off with every source enabled
		write_reg(addr_stat, 8'h78);
		write_reg(addr_lcdc, 8'h11);
		repeat (idle_cycles) @(negedge clk);
		write_reg(addr_stat, 8'h00);
		write_reg(addr_lcdc, 8'h00);

		// one frame each for the vblank, hblank, oam and lyc sources
		run_frame(8'h91, 8'h10);
		run_frame(8'h88, 8'h08);
		run_frame(8'h89, 8'h20);
		run_frame(8'h99, 8'h40);

		@(negedge clk);
		report = 1'b1;
		@(negedge clk);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

//--- tb.f
source/ppu_pkg.sv
source/ppu_regs.sv
source/ppu_ctrl.sv
source/bg_fetch.sv
source/pixel_out.sv
source/ppu_top.sv
tests/tb_clock.sv
tests/tb_check.sv
tests/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
